// ==== awg_pkg.sv ====
// sizes, vector types, trigger mode codes, state enums and stage structs
`default_nettype none

package awg_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////
  localparam int channels = 2;
  localparam int depth = 16;
  localparam int parallel_samples = 2;
  localparam int sample_width = 16;
  localparam int word_width = parallel_samples * sample_width;
  localparam int addr_width = $clog2(depth);
  // keep at least one bit even for a single channel
  localparam int chan_width = (channels > 1) ? $clog2(channels) : 1;
  localparam int burst_width = 16;

  //////////////////////////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////////////////////////
  typedef logic [word_width-1:0]  word_t;
  typedef logic [addr_width-1:0]  addr_t;
  typedef logic [chan_width-1:0]  chan_t;
  typedef logic [burst_width-1:0] burst_len_t;
  // 0 and 3 give no trigger
  typedef logic [1:0]             trig_mode_t;

  localparam trig_mode_t trig_burst = 2'd1;   // first frame of the burst only
  localparam trig_mode_t trig_frame = 2'd2;   // start of every frame

  //////////////////////////////////////////////////////////////////////
  // state machines
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {load_idle, load_accepting, load_blocking} load_state_t;
  typedef enum logic {play_idle, play_active} play_state_t;

  //////////////////////////////////////////////////////////////////////
  // stage structs
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    addr_t      addr_max;     // last address of the frame
    trig_mode_t trig_mode;
    burst_len_t burst_last;   // frames minus one
  } chan_cfg_t;

  typedef struct packed {
    logic  en;
    chan_t chan;
    addr_t addr;
    word_t data;
  } buf_write_t;

  typedef struct packed {
    addr_t [channels-1:0] addr;
    logic  [channels-1:0] blank;
    logic  [channels-1:0] trig;
  } read_req_t;

endpackage

`default_nettype wire

// ==== awg_loader.sv ====
// waveform loader: configuration registers, load FSM, start/stop pulses, buffer write pointer
`timescale 1ns/1ps
`default_nettype none

module awg_loader import awg_pkg::*; (
  input  logic                       dac_clk,
  input  logic                       dma_reset,
  // frame depth per channel, also kicks off a load
  input  logic                       depth_cfg_valid,
  output logic                       depth_cfg_ready,
  input  addr_t      [channels-1:0]  depth_cfg_data,
  // trigger mode per channel
  input  logic                       trig_cfg_valid,
  output logic                       trig_cfg_ready,
  input  trig_mode_t [channels-1:0]  trig_cfg_data,
  // frames per burst, per channel
  input  logic                       burst_cfg_valid,
  output logic                       burst_cfg_ready,
  input  burst_len_t [channels-1:0]  burst_cfg_data,
  // {start, stop}
  input  logic                       start_stop_valid,
  output logic                       start_stop_ready,
  input  logic       [1:0]           start_stop_data,
  // waveform words
  input  logic                       wave_valid,
  output logic                       wave_ready,
  input  word_t                      wave_data,
  input  logic                       wave_last,
  // burst finished, from the sequencer
  input  logic                       done,
  output chan_cfg_t  [channels-1:0]  cfg,
  output logic                       start,
  output logic                       stop,
  output buf_write_t                 wr
);

  load_state_t         state;
  logic                wave_accept;
  // registered input word
  logic                wr_en_q;
  word_t               wr_data_q;
  // write pointer
  chan_t               wr_chan;
  addr_t               wr_addr;
  logic [channels-1:0] wr_done;
  logic                wr_fire;
  logic                frame_end;
  logic                load_end;

  //////////////////////////////////////////////////////////////////////
  // stream handshakes
  //////////////////////////////////////////////////////////////////////
  assign depth_cfg_ready  = state == load_idle;
  assign trig_cfg_ready   = state == load_idle;
  assign burst_cfg_ready  = state == load_idle;
  assign wave_ready       = state == load_accepting;
  // playback may be started or stopped unless the buffer is being filled
  assign start_stop_ready = state != load_accepting;

  assign wave_accept = wave_valid & wave_ready;

  // a channel that has its whole frame takes no more words
  assign wr_fire   = wr_en_q & ~wr_done[wr_chan];
  assign frame_end = wr_addr == cfg[wr_chan].addr_max;
  // host ends with last, or last address of last channel got written
  assign load_end  = (wave_accept & wave_last)
                   | (wr_fire & frame_end & (wr_chan == chan_t'(channels - 1)));

  //////////////////////////////////////////////////////////////////////
  // load FSM
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      state <= load_idle;
    end else begin
      case (state)
        load_idle: if (depth_cfg_valid & depth_cfg_ready) state <= load_accepting;
        load_accepting: if (load_end) state <= load_blocking;
        load_blocking: if (stop | done) state <= load_idle;
        default: state <= load_idle;
      endcase
    end
  end

  // configuration and command pulses
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      cfg   <= '0;
      start <= 1'b0;
      stop  <= 1'b0;
    end else begin
      for (int ch = 0; ch < channels; ch++) begin
        if (depth_cfg_valid & depth_cfg_ready) begin
          cfg[ch].addr_max <= depth_cfg_data[ch];
        end
        if (trig_cfg_valid & trig_cfg_ready) begin
          cfg[ch].trig_mode <= trig_cfg_data[ch];
        end
        // stored as frames minus one, zero frames not supported
        if (burst_cfg_valid & burst_cfg_ready) begin
          cfg[ch].burst_last <= burst_cfg_data[ch] - 1'b1;
        end
      end
      // single-cycle pulses
      if (start_stop_valid & start_stop_ready) begin
        {start, stop} <= start_stop_data;
      end else begin
        {start, stop} <= 2'b00;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // write path
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge dac_clk) begin
    wr_data_q <= wave_data;
  end

  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      wr_en_q <= 1'b0;
      wr_chan <= '0;
      wr_addr <= '0;
      wr_done <= '0;
    end else begin
      wr_en_q <= wave_accept;
      if (state == load_idle) begin
        wr_chan <= '0;
        wr_addr <= '0;
        wr_done <= '0;
      end else if (wr_fire) begin
        if (frame_end) begin
          // frame complete, wrap and move to next channel
          wr_addr <= '0;
          wr_done[wr_chan] <= 1'b1;
          if (wr_chan == chan_t'(channels - 1)) begin
            wr_chan <= '0;
          end else begin
            wr_chan <= chan_t'(wr_chan + 1'b1);
          end
        end else begin
          wr_addr <= addr_t'(wr_addr + 1'b1);
        end
      end
    end
  end

  assign wr.en   = wr_fire;
  assign wr.chan = wr_chan;
  assign wr.addr = wr_addr;
  assign wr.data = wr_data_q;

endmodule

`default_nettype wire

// ==== awg_buffer.sv ====
// per-channel waveform memories with a two-stage registered read
`timescale 1ns/1ps
`default_nettype none

module awg_buffer import awg_pkg::*; (
  input  logic                   dac_clk,
  input  buf_write_t             wr,
  input  addr_t [channels-1:0]   rd_addr,
  output word_t [channels-1:0]   rd_data
);

  //////////////////////////////////////////////////////////////////////
  // one memory per channel
  //////////////////////////////////////////////////////////////////////
  for (genvar ch = 0; ch < channels; ch++) begin : g_chan
    word_t mem [depth];
    // memory output register
    word_t mem_q;
    // second pipeline stage
    word_t pipe_q;

    // only the channel under the write pointer takes the word
    always_ff @(posedge dac_clk) begin
      if (wr.en && (wr.chan == chan_t'(ch))) begin
        mem[wr.addr] <= wr.data;
      end
    end

    // every channel reads each cycle, two cycles to rd_data
    always_ff @(posedge dac_clk) begin
      mem_q  <= mem[rd_addr[ch]];
      pipe_q <= mem_q;
    end

    assign rd_data[ch] = pipe_q;
  end

endmodule

`default_nettype wire

// ==== awg_sequencer.sv ====
// playback FSM, per-channel address and frame counters, trigger, blank and done generation
`timescale 1ns/1ps
`default_nettype none

module awg_sequencer import awg_pkg::*; (
  input  logic                       dac_clk,
  input  logic                       dma_reset,
  input  chan_cfg_t [channels-1:0]   cfg,
  input  logic                       start,
  input  logic                       stop,
  output read_req_t                  req,
  output logic                       done
);

  play_state_t                state;
  logic                       active;
  addr_t      [channels-1:0]  addr_q;
  burst_len_t [channels-1:0]  frame_q;
  // set after the final address of the final frame
  logic       [channels-1:0]  chan_done;
  logic                       all_done;
  logic       [channels-1:0]  blank_m;
  logic       [channels-1:0]  trig_m;

  assign active   = state == play_active;
  assign all_done = &chan_done;

  //////////////////////////////////////////////////////////////////////
  // playback FSM
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      state <= play_idle;
    end else begin
      case (state)
        play_idle: if (start) state <= play_active;
        play_active: if (stop | all_done) state <= play_idle;
        default: state <= play_idle;
      endcase
    end
  end

  // leaves play_active on the same edge, so this is one cycle wide
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      done <= 1'b0;
    end else begin
      done <= active & all_done;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // address and frame counters
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      addr_q    <= '0;
      frame_q   <= '0;
      chan_done <= '0;
    end else if (!active) begin
      // idle, park everything at the start of the frame
      addr_q    <= '0;
      frame_q   <= '0;
      chan_done <= '0;
    end else begin
      for (int ch = 0; ch < channels; ch++) begin
        if (addr_q[ch] == cfg[ch].addr_max) begin
          addr_q[ch] <= '0;
          // end of frame, count it or close the burst
          if (frame_q[ch] == cfg[ch].burst_last) begin
            frame_q[ch]   <= '0;
            chan_done[ch] <= 1'b1;
          end else begin
            frame_q[ch] <= burst_len_t'(frame_q[ch] + 1'b1);
          end
        end else begin
          addr_q[ch] <= addr_t'(addr_q[ch] + 1'b1);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // blank and trigger masks, aligned with addr_q
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int ch = 0; ch < channels; ch++) begin
      blank_m[ch] = chan_done[ch] | ~active;
      trig_m[ch]  = 1'b0;
      // first word of a frame on a channel still playing
      if (active && !chan_done[ch] && (addr_q[ch] == '0)) begin
        if (cfg[ch].trig_mode == trig_frame) begin
          trig_m[ch] = 1'b1;
        end else if ((cfg[ch].trig_mode == trig_burst) && (frame_q[ch] == '0)) begin
          trig_m[ch] = 1'b1;
        end
      end
    end
  end

  assign req.addr  = addr_q;
  assign req.blank = blank_m;
  assign req.trig  = trig_m;

endmodule

`default_nettype wire

// ==== awg_output.sv ====
// output stage: mask delay to memory latency, zeroing of blanked channels, output registers
`timescale 1ns/1ps
`default_nettype none

module awg_output import awg_pkg::*; (
  input  logic                   dac_clk,
  input  logic                   dma_reset,
  input  word_t [channels-1:0]   rd_data,
  input  logic  [channels-1:0]   blank,
  input  logic  [channels-1:0]   trig,
  output word_t [channels-1:0]   dac_data,
  output logic  [channels-1:0]   dac_trigger
);

  // two stages, same as the buffer read
  logic [1:0][channels-1:0] blank_pipe;
  logic [1:0][channels-1:0] trig_pipe;

  //////////////////////////////////////////////////////////////////////
  // flag delay
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      // start blanked so nothing stale reaches the DAC
      blank_pipe <= '1;
      trig_pipe  <= '0;
    end else begin
      blank_pipe <= {blank_pipe[0], blank};
      trig_pipe  <= {trig_pipe[0], trig};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      dac_data    <= '0;
      dac_trigger <= '0;
    end else begin
      dac_trigger <= trig_pipe[1];
      for (int ch = 0; ch < channels; ch++) begin
        // finished or idle channels send zeros
        if (blank_pipe[1][ch]) begin
          dac_data[ch] <= '0;
        end else begin
          dac_data[ch] <= rd_data[ch];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== awg_top.sv ====
// waveform generator top: loader, buffer, sequencer and output stage
`timescale 1ns/1ps
`default_nettype none

module awg_top import awg_pkg::*; (
  input  logic                       dac_clk,
  input  logic                       dma_reset,
  // host configuration streams
  input  logic                       depth_cfg_valid,
  output logic                       depth_cfg_ready,
  input  addr_t      [channels-1:0]  depth_cfg_data,
  input  logic                       trig_cfg_valid,
  output logic                       trig_cfg_ready,
  input  trig_mode_t [channels-1:0]  trig_cfg_data,
  input  logic                       burst_cfg_valid,
  output logic                       burst_cfg_ready,
  input  burst_len_t [channels-1:0]  burst_cfg_data,
  input  logic                       start_stop_valid,
  output logic                       start_stop_ready,
  input  logic       [1:0]           start_stop_data,
  // waveform stream
  input  logic                       wave_valid,
  output logic                       wave_ready,
  input  word_t                      wave_data,
  input  logic                       wave_last,
  // DAC side
  output word_t      [channels-1:0]  dac_data,
  output logic       [channels-1:0]  dac_trigger
);

  buf_write_t                wr;
  chan_cfg_t [channels-1:0]  cfg;
  logic                      start;
  logic                      stop;
  logic                      done;
  read_req_t                 req;
  word_t     [channels-1:0]  rd_data;

  //////////////////////////////////////////////////////////////////////
  // load side
  //////////////////////////////////////////////////////////////////////
  awg_loader loader_i (
    .dac_clk          (dac_clk),
    .dma_reset        (dma_reset),
    .depth_cfg_valid  (depth_cfg_valid),
    .depth_cfg_ready  (depth_cfg_ready),
    .depth_cfg_data   (depth_cfg_data),
    .trig_cfg_valid   (trig_cfg_valid),
    .trig_cfg_ready   (trig_cfg_ready),
    .trig_cfg_data    (trig_cfg_data),
    .burst_cfg_valid  (burst_cfg_valid),
    .burst_cfg_ready  (burst_cfg_ready),
    .burst_cfg_data   (burst_cfg_data),
    .start_stop_valid (start_stop_valid),
    .start_stop_ready (start_stop_ready),
    .start_stop_data  (start_stop_data),
    .wave_valid       (wave_valid),
    .wave_ready       (wave_ready),
    .wave_data        (wave_data),
    .wave_last        (wave_last),
    .done             (done),
    .cfg              (cfg),
    .start            (start),
    .stop             (stop),
    .wr               (wr)
  );

  awg_buffer buffer_i (
    .dac_clk (dac_clk),
    .wr      (wr),
    .rd_addr (req.addr),
    .rd_data (rd_data)
  );

  //////////////////////////////////////////////////////////////////////
  // playback side
  //////////////////////////////////////////////////////////////////////
  awg_sequencer sequencer_i (
    .dac_clk   (dac_clk),
    .dma_reset (dma_reset),
    .cfg       (cfg),
    .start     (start),
    .stop      (stop),
    .req       (req),
    .done      (done)
  );

  awg_output output_i (
    .dac_clk     (dac_clk),
    .dma_reset   (dma_reset),
    .rd_data     (rd_data),
    .blank       (req.blank),
    .trig        (req.trig),
    .dac_data    (dac_data),
    .dac_trigger (dac_trigger)
  );

endmodule

`default_nettype wire

// ==== awg_asserts.sv ====
// concurrent assertions on stream readies, the done pulse and trigger against data
`timescale 1ns/1ps
`default_nettype none

module awg_asserts import awg_pkg::*; (
  input logic                  dac_clk,
  input logic                  dma_reset,
  input logic                  depth_cfg_ready,
  input logic                  trig_cfg_ready,
  input logic                  burst_cfg_ready,
  input logic                  wave_ready,
  input logic                  done,
  input word_t [channels-1:0]  dac_data,
  input logic  [channels-1:0]  dac_trigger
);

  // failures seen so far, read by the testbench at the end
  int assert_errors = 0;

  // words and configuration are never taken in the same state
  ready_exclusive: assert property (@(posedge dac_clk) disable iff (dma_reset)
    !(wave_ready && (depth_cfg_ready || trig_cfg_ready || burst_cfg_ready)))
    else begin
      assert_errors++;
      $error("wave_ready high together with a configuration ready");
    end

  // done lasts one cycle
  done_single: assert property (@(posedge dac_clk) disable iff (dma_reset)
    done |=> !done)
    else begin
      assert_errors++;
      $error("done held for more than one cycle");
    end

  // a trigger always comes with a played word
  for (genvar ch = 0; ch < channels; ch++) begin : g_trig
    trig_with_data: assert property (@(posedge dac_clk) disable iff (dma_reset)
      dac_trigger[ch] |-> (dac_data[ch] != '0))
      else begin
        assert_errors++;
        $error("dac_trigger[%0d] high while dac_data is zero", ch);
      end
  end

endmodule

`default_nettype wire

// ==== tb_awg.sv ====
// testbench for the waveform generator: clock, stimulus, reference model, comparison, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_awg import awg_pkg::*; ();

  // cycle limits for handshakes, stream start and the zero tail after a burst
  localparam int ready_limit = 200;
  localparam int start_limit = 64;
  localparam int tail_cycles = 40;
  // sum of the longest burst in each test
  // the stopped burst counts in full
  localparam int burst_sum = 13;
  localparam int num_tests = 5;
  localparam int timeout_cycles = burst_sum * depth
                                + num_tests * (4 * channels * depth + tail_cycles + 100);

  typedef struct packed {
    logic  trig;
    word_t data;
  } sample_t;

  logic                      dac_clk;
  logic                      dma_reset;
  logic                      depth_cfg_valid;
  logic                      depth_cfg_ready;
  addr_t      [channels-1:0] depth_cfg_data;
  logic                      trig_cfg_valid;
  logic                      trig_cfg_ready;
  trig_mode_t [channels-1:0] trig_cfg_data;
  logic                      burst_cfg_valid;
  logic                      burst_cfg_ready;
  burst_len_t [channels-1:0] burst_cfg_data;
  logic                      start_stop_valid;
  logic                      start_stop_ready;
  logic       [1:0]          start_stop_data;
  logic                      wave_valid;
  logic                      wave_ready;
  word_t                     wave_data;
  logic                      wave_last;
  word_t      [channels-1:0] dac_data;
  logic       [channels-1:0] dac_trigger;

  // model of what the host loaded
  word_t      frame_mem [channels][depth];
  addr_t      cur_max   [channels];
  trig_mode_t cur_mode  [channels];
  int         cur_burst [channels];
  int         exp_len   [channels];
  logic [31:0] lcg_state;
  int check_count;
  int err_count;
  int fail_count;

  awg_top dut (.*);

  bind awg_top awg_asserts asserts_i (
    .dac_clk         (dac_clk),
    .dma_reset       (dma_reset),
    .depth_cfg_ready (depth_cfg_ready),
    .trig_cfg_ready  (trig_cfg_ready),
    .burst_cfg_ready (burst_cfg_ready),
    .wave_ready      (wave_ready),
    .done            (done),
    .dac_data        (dac_data),
    .dac_trigger     (dac_trigger)
  );

  initial begin
    dac_clk = 1'b0;
    forever #2 dac_clk = ~dac_clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model and checking
  //////////////////////////////////////////////////////////////////////
  function automatic word_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // bit 0 set so a loaded word is never zero
    return lcg_state | 32'd1;
  endfunction

  // word and trigger at position idx of a channel's burst
  function automatic sample_t expected_sample(input int ch, input int idx);
    sample_t s;
    int len;
    int pos;
    len = int'(cur_max[ch]) + 1;
    pos = idx % len;
    s.data = frame_mem[ch][pos];
    s.trig = 1'b0;
    if (pos == 0) begin
      // mode 2 every frame, mode 1 first frame only, 0 and 3 never
      if (cur_mode[ch] == 2'd2) begin
        s.trig = 1'b1;
      end else if ((cur_mode[ch] == 2'd1) && (idx < len)) begin
        s.trig = 1'b1;
      end
    end
    return s;
  endfunction

  task automatic check_val(input string name, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    fail_count++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic print_counts();
    $display("checks %0d, value errors %0d, other failures %0d",
             check_count, err_count, fail_count);
  endtask

  //////////////////////////////////////////////////////////////////////
  // host side stimulus
  //////////////////////////////////////////////////////////////////////
  task automatic wait_config_ready();
    int n;
    n = 0;
    @(negedge dac_clk);
    while (!depth_cfg_ready && (n < ready_limit)) begin
      n++;
      @(negedge dac_clk);
    end
    if (!depth_cfg_ready) begin
      report_failure("configuration streams did not become ready");
    end else begin
      check_val("trig_cfg_ready", word_t'(trig_cfg_ready), 32'd1);
      check_val("burst_cfg_ready", word_t'(burst_cfg_ready), 32'd1);
      check_val("wave_ready", word_t'(wave_ready), 32'd0);
    end
  endtask

  // all three configuration words in one transfer
  // returns on the transfer edge
  task automatic configure(input addr_t [channels-1:0] max_v,
                           input trig_mode_t [channels-1:0] mode_v,
                           input burst_len_t [channels-1:0] burst_v);
    wait_config_ready();
    @(posedge dac_clk);
    depth_cfg_valid <= 1'b1;
    depth_cfg_data  <= max_v;
    trig_cfg_valid  <= 1'b1;
    trig_cfg_data   <= mode_v;
    burst_cfg_valid <= 1'b1;
    burst_cfg_data  <= burst_v;
    @(posedge dac_clk);
    depth_cfg_valid <= 1'b0;
    trig_cfg_valid  <= 1'b0;
    burst_cfg_valid <= 1'b0;
    for (int ch = 0; ch < channels; ch++) begin
      cur_max[ch]   = max_v[ch];
      cur_mode[ch]  = mode_v[ch];
      cur_burst[ch] = int'(burst_v[ch]);
    end
  endtask

  // channel 0 frame first and then channel 1
  // called on a rising edge
  task automatic load_wave(input logic use_last);
    int n;
    word_t w;
    logic last_flag;
    for (int ch = 0; ch < channels; ch++) begin
      for (int a = 0; a <= int'(cur_max[ch]); a++) begin
        w = next_rand();
        frame_mem[ch][a] = w;
        last_flag = use_last && (ch == channels - 1) && (a == int'(cur_max[ch]));
        wave_valid <= 1'b1;
        wave_data  <= w;
        wave_last  <= last_flag;
        n = 0;
        @(negedge dac_clk);
        while (!wave_ready && (n < ready_limit)) begin
          n++;
          @(negedge dac_clk);
        end
        if (!wave_ready) begin
          report_failure("wave_in never became ready during the load");
          wave_valid <= 1'b0;
          return;
        end
        // no configuration or command while the buffer fills
        check_val("depth_cfg_ready", word_t'(depth_cfg_ready), 32'd0);
        check_val("start_stop_ready", word_t'(start_stop_ready), 32'd0);
        @(posedge dac_clk);
      end
    end
    wave_valid <= 1'b0;
    wave_last  <= 1'b0;
    // load over and waiting for a command
    repeat (3) @(posedge dac_clk);
    @(negedge dac_clk);
    check_val("wave_ready", word_t'(wave_ready), 32'd0);
    check_val("start_stop_ready", word_t'(start_stop_ready), 32'd1);
    check_val("depth_cfg_ready", word_t'(depth_cfg_ready), 32'd0);
  endtask

  // sends {start, stop} and returns on the transfer edge
  task automatic send_ctrl(input logic [1:0] cmd);
    int n;
    n = 0;
    @(negedge dac_clk);
    while (!start_stop_ready && (n < ready_limit)) begin
      n++;
      @(negedge dac_clk);
    end
    if (!start_stop_ready) begin
      report_failure("start_stop never became ready");
      return;
    end
    @(posedge dac_clk);
    start_stop_valid <= 1'b1;
    start_stop_data  <= cmd;
    @(posedge dac_clk);
    start_stop_valid <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // output comparison
  //////////////////////////////////////////////////////////////////////
  task automatic compare_channel(input int ch);
    int n;
    sample_t s;
    string data_name;
    string trig_name;
    data_name = $sformatf("dac_data[%0d]", ch);
    trig_name = $sformatf("dac_trigger[%0d]", ch);
    n = 0;
    @(negedge dac_clk);
    while ((dac_data[ch] == '0) && (n < start_limit)) begin
      n++;
      @(negedge dac_clk);
    end
    if (dac_data[ch] == '0) begin
      report_failure($sformatf("channel %0d output stream never started", ch));
      return;
    end
    for (int i = 0; i < exp_len[ch]; i++) begin
      s = expected_sample(ch, i);
      check_val(data_name, dac_data[ch], s.data);
      check_val(trig_name, word_t'(dac_trigger[ch]), word_t'(s.trig));
      @(negedge dac_clk);
    end
    // finished or stopped channel holds zeros
    for (int i = 0; i < tail_cycles; i++) begin
      check_val(data_name, dac_data[ch], 32'd0);
      check_val(trig_name, word_t'(dac_trigger[ch]), 32'd0);
      @(negedge dac_clk);
    end
  endtask

  // stop_gap 0 plays to the end, else a stop goes out stop_gap edges after start
  task automatic run_burst(input int stop_gap);
    for (int ch = 0; ch < channels; ch++) begin
      exp_len[ch] = cur_burst[ch] * (int'(cur_max[ch]) + 1);
      // start and stop transfers are stop_gap + 2 edges apart with one address per cycle
      if ((stop_gap > 0) && (stop_gap + 2 < exp_len[ch])) begin
        exp_len[ch] = stop_gap + 2;
      end
    end
    fork
      compare_channel(0);
      compare_channel(1);
      begin
        send_ctrl(2'b10);
        @(negedge dac_clk);
        check_val("depth_cfg_ready", word_t'(depth_cfg_ready), 32'd0);
        check_val("trig_cfg_ready", word_t'(trig_cfg_ready), 32'd0);
        check_val("burst_cfg_ready", word_t'(burst_cfg_ready), 32'd0);
        @(posedge dac_clk);
        if (stop_gap > 0) begin
          repeat (stop_gap - 1) @(posedge dac_clk);
          send_ctrl(2'b01);
        end
      end
    join
    // done or stop hands control back to the host
    wait_config_ready();
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    dma_reset        <= 1'b1;
    depth_cfg_valid  <= 1'b0;
    depth_cfg_data   <= '0;
    trig_cfg_valid   <= 1'b0;
    trig_cfg_data    <= '0;
    burst_cfg_valid  <= 1'b0;
    burst_cfg_data   <= '0;
    start_stop_valid <= 1'b0;
    start_stop_data  <= '0;
    wave_valid       <= 1'b0;
    wave_data        <= '0;
    wave_last        <= 1'b0;
    lcg_state   = 32'd229;
    check_count = 0;
    err_count   = 0;
    fail_count  = 0;
    repeat (10) @(posedge dac_clk);
    dma_reset <= 1'b0;
    @(negedge dac_clk);
    check_val("dac_data[0]", dac_data[0], 32'd0);
    check_val("dac_data[1]", dac_data[1], 32'd0);
    check_val("dac_trigger", word_t'(dac_trigger), 32'd0);
    check_val("start_stop_ready", word_t'(start_stop_ready), 32'd1);

    // full depth, trigger on the first word only, three frames
    configure({addr_t'(15), addr_t'(15)}, {trig_mode_t'(1), trig_mode_t'(1)},
              {burst_len_t'(3), burst_len_t'(3)});
    load_wave(1'b1);
    run_burst(0);

    // short and long frames, per-frame trigger on channel 0 only
    configure({addr_t'(3), addr_t'(7)}, {trig_mode_t'(0), trig_mode_t'(2)},
              {burst_len_t'(2), burst_len_t'(2)});
    load_wave(1'b1);
    run_burst(0);

    // stop in the second frame
    configure({addr_t'(15), addr_t'(15)}, {trig_mode_t'(2), trig_mode_t'(1)},
              {burst_len_t'(4), burst_len_t'(4)});
    load_wave(1'b1);
    run_burst(18);

    // exact word count, no last flag, mode 3 acts as no trigger
    configure({addr_t'(5), addr_t'(9)}, {trig_mode_t'(2), trig_mode_t'(3)},
              {burst_len_t'(3), burst_len_t'(2)});
    load_wave(1'b0);
    run_burst(0);

    // fresh load after a finished burst
    configure({addr_t'(12), addr_t'(4)}, {trig_mode_t'(1), trig_mode_t'(2)},
              {burst_len_t'(1), burst_len_t'(1)});
    load_wave(1'b1);
    run_burst(0);

    fail_count = fail_count + dut.asserts_i.assert_errors;
    print_counts();
    if ((err_count == 0) && (fail_count == 0)) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (timeout_cycles) @(posedge dac_clk);
    report_failure("timeout, the tests did not finish in time");
    print_counts();
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
awg_pkg.sv
awg_loader.sv
awg_buffer.sv
awg_sequencer.sv
awg_output.sv
awg_top.sv
awg_asserts.sv
tb_awg.sv

// ==== run.sh ====
#!/bin/sh
# build and run the waveform generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_awg -o tb_awg_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_awg_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1
